/* compile.f */
+incdir+common
common/div_op_pkg.sv
common/div_data_pkg.sv
divider/div_prep.sv
divider/div_iter_core.sv
divider/div_result_fmt.sv
hdl/div_unit_top.sv
tests/div_unit_asserts.sv
tests/div_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the divider testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module div_unit_tb \
  -f compile.f -o Vdiv_unit_tb \
  || { echo "build failed"; exit 1; }

./obj_dir/Vdiv_unit_tb > sim.log 2>&1
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

/* tests/div_unit_tb.sv */
// directed testbench for the divide unit, compiled as top module together with the bound checks
`timescale 1ns/1ps
`include "div_defs.svh"

module div_unit_tb
  import div_op_pkg::*, div_data_pkg::*;
();

  localparam int TIMEOUT     = 200; // cycles per wait
  localparam int LAT_SPECIAL = 0;   // result right after the accepting edge
  localparam int LAT_DWORD   = 65;  // 64 iterations plus the finishing check
  localparam int LAT_WORD    = 33;

  logic     clk;
  logic     rst_n;
  logic     req_valid_i;
  logic     req_ready_o;
  div_req_t req_i;
  logic     resp_valid_o;
  logic     resp_ready_i;
  xlen_t    resp_o;

  int   errors;
  int   timeouts;
  int   checks;
  int   seed;
  logic aborted; // set on a timeout, later tests are skipped

  div_unit_top div_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_o       (resp_o)
  );

  always #2 clk = ~clk;

  // ==================================================
  // reference model
  // ==================================================
  function automatic xlen_t sext_word(logic [`DIV_WLEN-1:0] v);
    return {{(`DIV_XLEN-`DIV_WLEN){v[`DIV_WLEN-1]}}, v};
  endfunction

  // expected result and latency by the rv64m rules
  task automatic model(input div_op_t code, input xlen_t a, input xlen_t b,
                       output xlen_t res, output int lat);
    logic                        sgn;
    logic                        word;
    logic                        rem;
    xlen_t                       ua;
    xlen_t                       ub;
    xlen_t                       q;
    xlen_t                       r;
    xlen_t                       min_val;
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    sgn  = code inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
    word = code inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    rem  = code inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
    ua = !word ? a : sgn ? sext_word(a[`DIV_WLEN-1:0]) : {32'b0, a[`DIV_WLEN-1:0]};
    ub = !word ? b : sgn ? sext_word(b[`DIV_WLEN-1:0]) : {32'b0, b[`DIV_WLEN-1:0]};
    min_val = word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
    lat = word ? LAT_WORD : LAT_DWORD;
    if (ub == '0) begin
      q   = '1;
      r   = ua;
      lat = LAT_SPECIAL;
    end else if (sgn && ua == min_val && ub == '1) begin
      q   = ua;
      r   = '0;
      lat = LAT_SPECIAL;
    end else if (sgn) begin
      sa = ua;
      sb = ub;
      q  = sa / sb; // truncates toward zero
      r  = sa % sb; // sign of the dividend
    end else begin
      q = ua / ub;
      r = ua % ub;
    end
    res = rem ? r : q;
    if (word)
      res = sext_word(res[`DIV_WLEN-1:0]);
  endtask

  // ==================================================
  // checks and handshakes
  // ==================================================
  task automatic check_eq(string what, xlen_t got, xlen_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error @ %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!req_ready_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!req_ready_o) begin
      timeouts++;
      aborted = 1'b1;
      $display("timeout: the divider never became ready for a new request");
    end
  endtask

  // counts edges after the accepting one until resp_valid_o is seen
  task automatic wait_resp(output int lat);
    lat = 0;
    @(negedge clk);
    while (!resp_valid_o && lat < TIMEOUT) begin
      @(negedge clk);
      lat++;
    end
    if (!resp_valid_o) begin
      timeouts++;
      aborted = 1'b1;
      $display("timeout: no response from the divider");
    end
  endtask

  task automatic send_req(div_op_t code, xlen_t a, xlen_t b);
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= '{op: code, dividend: a, divisor: b};
    wait_ready();
    @(posedge clk); // accepting edge
    req_valid_i <= 1'b0;
  endtask

  task automatic run_op(div_op_t code, xlen_t a, xlen_t b);
    xlen_t exp;
    int    exp_lat;
    int    lat;
    string tag;
    if (aborted)
      return;
    tag = $sformatf("%s %h / %h", code.name(), a, b);
    model(code, a, b, exp, exp_lat);
    send_req(code, a, b);
    wait_resp(lat);
    if (aborted)
      return;
    check_eq({tag, " result"}, resp_o, exp);
    check_eq({tag, " latency"}, xlen_t'(lat), xlen_t'(exp_lat));
    @(posedge clk); // taken here, resp_ready_i is high
  endtask

  // ==================================================
  // tests
  // ==================================================
  task automatic test_reset();
    @(negedge clk);
    check_eq("req_ready_o after reset", xlen_t'(req_ready_o), 64'd1);
    check_eq("resp_valid_o after reset", xlen_t'(resp_valid_o), 64'd0);
  endtask

  task automatic test_unsigned();
    xlen_t a;
    xlen_t b;
    run_op(OP_DIVU, 64'd100, 64'd7);
    run_op(OP_REMU, 64'd100, 64'd7);
    run_op(OP_DIVU, 64'd5, 64'd9); // dividend below divisor
    run_op(OP_REMU, 64'd5, 64'd9);
    run_op(OP_DIVU, '1, 64'd3);
    run_op(OP_REMU, 64'hffff_ffff_ffff_fff0, 64'h8000_0000_0000_0001); // top bit divisor
    for (int i = 0; i < 8; i++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)} >> ($unsigned($random(seed)) % 64);
      run_op(OP_DIVU, a, b);
      run_op(OP_REMU, a, b);
    end
  endtask

  task automatic test_signed();
    xlen_t a;
    xlen_t b;
    for (int i = 0; i < 4; i++) begin
      a = i[0] ? -64'd7 : 64'd7;
      b = i[1] ? -64'd2 : 64'd2;
      run_op(OP_DIV, a, b);
      run_op(OP_REM, a, b);
      a = i[0] ? -64'h0123_4567_89ab_cdef : 64'h0123_4567_89ab_cdef;
      b = i[1] ? -64'd1000 : 64'd1000;
      run_op(OP_DIV, a, b);
      run_op(OP_REM, a, b);
    end
  endtask

  task automatic test_word();
    xlen_t a;
    xlen_t b;
    run_op(OP_DIVW, 64'hdead_beef_ffff_fff9, 64'h1234_5678_0000_0002); // -7 / 2
    run_op(OP_REMW, 64'hdead_beef_ffff_fff9, 64'h1234_5678_0000_0002);
    run_op(OP_DIVUW, 64'hdead_beef_f000_0000, 64'hcafe_0000_0000_0001); // bit 31 set
    run_op(OP_REMUW, 64'hffff_0000_8000_0007, 64'h0000_ffff_0000_0010);
    for (int i = 0; i < 4; i++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)} >> ($unsigned($random(seed)) % 32);
      run_op(OP_DIVW, a, b);
      run_op(OP_DIVUW, a, b);
      run_op(OP_REMW, a, b);
      run_op(OP_REMUW, a, b);
    end
  endtask

  task automatic test_special();
    div_op_t ops [8] = '{OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW,
                         OP_REM, OP_REMU, OP_REMUW, OP_REMW};
    foreach (ops[i]) begin
      run_op(ops[i], 64'h1234_5678_9abc_def0, 64'd0);
      run_op(ops[i], 64'h8765_4321_8000_0005, 64'habcd_0000_0000_0000); // zero low half
    end
    run_op(OP_DIV, 64'h8000_0000_0000_0000, '1);
    run_op(OP_REM, 64'h8000_0000_0000_0000, '1);
    run_op(OP_DIVW, 64'h0000_1111_8000_0000, 64'h0000_2222_ffff_ffff);
    run_op(OP_REMW, 64'h0000_1111_8000_0000, 64'h0000_2222_ffff_ffff);
  endtask

  task automatic test_backpressure();
    xlen_t exp;
    xlen_t held;
    int    exp_lat;
    int    lat;
    if (aborted)
      return;
    model(OP_DIV, -64'd1000, 64'd7, exp, exp_lat);
    @(posedge clk);
    resp_ready_i <= 1'b0;
    send_req(OP_DIV, -64'd1000, 64'd7);
    wait_resp(lat);
    if (aborted)
      return;
    held = resp_o;
    check_eq("stalled result", held, exp);
    repeat (6) begin
      @(negedge clk);
      check_eq("resp_o under stall", resp_o, held);
      check_eq("resp_valid_o under stall", xlen_t'(resp_valid_o), 64'd1);
      check_eq("req_ready_o under stall", xlen_t'(req_ready_o), 64'd0);
    end
    @(posedge clk);
    resp_ready_i <= 1'b1;
    req_valid_i  <= 1'b1;  // next request already waiting
    req_i        <= '{op: OP_REMU, dividend: 64'd1000, divisor: 64'd7};
    @(posedge clk);        // stalled response taken
    @(negedge clk);
    check_eq("req_ready_o after take", xlen_t'(req_ready_o), 64'd1);
    @(posedge clk);        // back-to-back accept
    req_valid_i <= 1'b0;
    model(OP_REMU, 64'd1000, 64'd7, exp, exp_lat);
    wait_resp(lat);
    if (aborted)
      return;
    check_eq("back-to-back result", resp_o, exp);
    check_eq("back-to-back latency", xlen_t'(lat), xlen_t'(exp_lat));
    @(posedge clk);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    errors       = 0;
    timeouts     = 0;
    checks       = 0;
    aborted      = 1'b0;
    seed         = 17;
    clk          = 1'b0;
    rst_n        = 1'b1;
    req_valid_i  = 1'b0;
    resp_ready_i = 1'b1;
    req_i        = '{op: OP_DIVU, dividend: '0, divisor: '0};
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;
    test_reset();
    test_unsigned();
    test_signed();
    test_word();
    test_special();
    test_backpressure();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* tests/div_unit_asserts.sv */
// handshake protocol checks for the divide unit, attached to div_unit_top with bind
`timescale 1ns/1ps
`include "div_defs.svh"

module div_unit_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req_ready_i,
  input logic                 resp_valid_i,
  input logic                 resp_ready_i,
  input logic [`DIV_XLEN-1:0] resp_i
);

  // ==================================================
  // handshake properties
  // ==================================================
  ready_valid_excl: assert property (@(posedge clk) disable iff (rst_n)
    !(req_ready_i && resp_valid_i))
    else $error("req_ready_o and resp_valid_o high in the same cycle");

  // stalled response must not move
  resp_stable: assert property (@(posedge clk) disable iff (rst_n)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else $error("response changed or dropped while stalled");

  valid_low_after_reset: assert property (@(posedge clk)
    rst_n |=> !resp_valid_i)
    else $error("resp_valid_o high in the cycle after reset");

endmodule

bind div_unit_top div_unit_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_i       (resp_o)
);

/* hdl/div_unit_top.sv */
// top level of the rv64 divide unit, instantiated by the execution stage
`timescale 1ns/1ps
`include "div_defs.svh"

module div_unit_top
  import div_op_pkg::*, div_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  div_req_t req_i,
  output logic     resp_valid_o,
  input  logic     resp_ready_i,
  output xlen_t    resp_o
);

  div_prep_t prep;  // combinational, sampled at accept
  div_raw_t  raw;   // registered in the core

  // ==================================================
  // stages
  // ==================================================
  div_prep u_prep (
    .req_i  (req_i),
    .prep_o (prep)
  );

  div_iter_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .prep_i       (prep),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .raw_o        (raw)
  );

  div_result_fmt u_fmt (
    .raw_i    (raw),
    .result_o (resp_o)
  );

endmodule

/* divider/div_result_fmt.sv */
// final result stage of the divider, restores signs and picks quotient or remainder
`timescale 1ns/1ps
`include "div_defs.svh"

module div_result_fmt
  import div_data_pkg::*;
(
  input  div_raw_t raw_i,
  output xlen_t    result_o
);

  xlen_t quot_val;
  xlen_t rem_val;
  xlen_t pick;

  // ==================================================
  // sign restore
  // ==================================================

  // two's complement of the magnitude
  assign quot_val = raw_i.q_neg ? -raw_i.quot_mag : raw_i.quot_mag;
  assign rem_val  = raw_i.r_neg ? -raw_i.rem_mag  : raw_i.rem_mag;

  // ==================================================
  // select and width
  // ==================================================
  assign pick = raw_i.want_rem ? rem_val : quot_val;

  // word results always sign-extended, also for divuw/remuw
  assign result_o = raw_i.is_word
                  ? {{(`DIV_XLEN-`DIV_WLEN){pick[`DIV_WLEN-1]}}, pick[`DIV_WLEN-1:0]}
                  : pick;

endmodule

/* divider/div_iter_core.sv */
// restoring shift-subtract divider core with request and response handshakes
`timescale 1ns/1ps
`include "div_defs.svh"

module div_iter_core
  import div_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  div_prep_t prep_i,
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output div_raw_t  raw_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ITER,
    ST_FINISH
  } state_t;

  state_t                  state_q;
  state_t                  state_d;
  cnt_t                    cnt_q;
  logic [2*`DIV_XLEN-1:0]  rq_q;      // {remainder, quotient}
  xlen_t                   divisor_q;
  logic                    q_neg_q;
  logic                    r_neg_q;
  logic                    is_word_q;
  logic                    want_rem_q;
  logic                    accept;
  logic                    iter_last;
  logic [`DIV_XLEN:0]      partial;   // one extra bit for large divisors
  logic                    fits;
  xlen_t                   rem_sub;

  assign accept    = req_valid_i & req_ready_o;
  assign iter_last = (cnt_q == '0);

  // ==================================================
  // control
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (req_valid_i) state_d = prep_i.is_special ? ST_FINISH : ST_ITER;
      ST_ITER:   if (iter_last) state_d = ST_FINISH; // the finishing check
      ST_FINISH: if (resp_ready_i) state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept)
        cnt_q <= prep_i.iter_count;
      else if (state_q == ST_ITER && !iter_last)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  // ==================================================
  // datapath
  // ==================================================

  // upper half shifted left with the next dividend bit
  assign partial = rq_q[2*`DIV_XLEN-1:`DIV_XLEN-1];
  assign fits    = (partial >= {1'b0, divisor_q});
  assign rem_sub = partial[`DIV_XLEN-1:0] - divisor_q; // exact when fits

  always_ff @(posedge clk) begin
    if (accept) begin
      divisor_q  <= prep_i.divisor_mag;
      q_neg_q    <= prep_i.q_neg;
      r_neg_q    <= prep_i.r_neg;
      is_word_q  <= prep_i.is_word;
      want_rem_q <= prep_i.want_rem;
      if (prep_i.is_special)
        rq_q <= {prep_i.special_rem, prep_i.special_quot}; // final values, no iteration
      else
        rq_q <= {{`DIV_XLEN{1'b0}}, prep_i.dividend_mag};
    end else if (state_q == ST_ITER && !iter_last) begin
      if (fits)
        rq_q <= {rem_sub, rq_q[`DIV_XLEN-2:0], 1'b1};
      else
        rq_q <= {partial[`DIV_XLEN-1:0], rq_q[`DIV_XLEN-2:0], 1'b0};
    end
  end

  // ==================================================
  // outputs
  // ==================================================
  assign req_ready_o  = (state_q == ST_IDLE);
  assign resp_valid_o = (state_q == ST_FINISH);

  always_comb begin
    raw_o.quot_mag = rq_q[`DIV_XLEN-1:0];
    raw_o.rem_mag  = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];
    raw_o.q_neg    = q_neg_q;
    raw_o.r_neg    = r_neg_q;
    raw_o.is_word  = is_word_q;
    raw_o.want_rem = want_rem_q;
  end

endmodule

/* divider/div_prep.sv */
// operand conditioning for the divider, decodes the op and flags the special cases
`timescale 1ns/1ps
`include "div_defs.svh"

module div_prep
  import div_op_pkg::*, div_data_pkg::*;
(
  input  div_req_t  req_i,
  output div_prep_t prep_o
);

  logic  is_signed;
  logic  is_word;
  logic  want_rem;
  xlen_t a_ext;
  xlen_t b_ext;
  xlen_t a_abs;
  xlen_t b_abs;
  xlen_t min_val;
  logic  a_neg;
  logic  b_neg;
  logic  div_zero;
  logic  overflow;
  logic  special;

  // ==================================================
  // op decode
  // ==================================================
  always_comb begin
    is_signed = 1'b0;
    is_word   = 1'b0;
    want_rem  = 1'b0;
    case (req_i.op)
      OP_DIV:   is_signed = 1'b1;
      OP_DIVU:  ;
      OP_DIVUW: is_word = 1'b1;
      OP_DIVW: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
      end
      OP_REM: begin
        is_signed = 1'b1;
        want_rem  = 1'b1;
      end
      OP_REMU:  want_rem = 1'b1;
      OP_REMUW: begin
        is_word  = 1'b1;
        want_rem = 1'b1;
      end
      OP_REMW: begin
        is_signed = 1'b1;
        is_word   = 1'b1;
        want_rem  = 1'b1;
      end
      default: ; // unknown code runs as divu
    endcase
  end

  // ==================================================
  // operand extension and magnitudes
  // ==================================================

  // word ops see only the low half, sign or zero filled
  assign a_ext = is_word ? {{(`DIV_XLEN-`DIV_WLEN){is_signed & req_i.dividend[`DIV_WLEN-1]}},
                            req_i.dividend[`DIV_WLEN-1:0]}
                         : req_i.dividend;
  assign b_ext = is_word ? {{(`DIV_XLEN-`DIV_WLEN){is_signed & req_i.divisor[`DIV_WLEN-1]}},
                            req_i.divisor[`DIV_WLEN-1:0]}
                         : req_i.divisor;

  assign a_neg = is_signed & a_ext[`DIV_XLEN-1];
  assign b_neg = is_signed & b_ext[`DIV_XLEN-1];
  assign a_abs = a_neg ? -a_ext : a_ext;
  assign b_abs = b_neg ? -b_ext : b_ext;

  // ==================================================
  // special cases
  // ==================================================

  // most negative value of the op width, after extension
  assign min_val = is_word ? {{(`DIV_XLEN-`DIV_WLEN+1){1'b1}}, {(`DIV_WLEN-1){1'b0}}}
                           : {1'b1, {(`DIV_XLEN-1){1'b0}}};

  assign div_zero = (b_ext == '0);            // ext keeps zero iff low part zero
  assign overflow = is_signed & (a_ext == min_val) & (&b_ext);
  assign special  = div_zero | overflow;

  // ==================================================
  // output
  // ==================================================
  always_comb begin
    prep_o.dividend_mag = is_word ? {a_abs[`DIV_WLEN-1:0], {(`DIV_XLEN-`DIV_WLEN){1'b0}}}
                                  : a_abs;  // word dividend high-aligned
    prep_o.divisor_mag  = b_abs;
    prep_o.iter_count   = is_word ? cnt_t'(`DIV_WLEN) : cnt_t'(`DIV_XLEN);
    prep_o.q_neg        = ~special & (a_neg ^ b_neg);
    prep_o.r_neg        = ~special & a_neg; // remainder follows dividend
    prep_o.is_word      = is_word;
    prep_o.want_rem     = want_rem;
    prep_o.is_special   = special;
    prep_o.special_quot = div_zero ? '1 : a_ext;   // overflow gives dividend back
    prep_o.special_rem  = div_zero ? a_ext : '0;
  end

endmodule

/* common/div_data_pkg.sv */
// datapath types shared by the divider stages, prep to core to formatter
`include "div_defs.svh"

package div_data_pkg;

  typedef logic [`DIV_XLEN-1:0]  xlen_t; // operand or result
  typedef logic [`DIV_CNT_W-1:0] cnt_t;  // iterations left

  // conditioned request handed to the iteration core
  typedef struct packed {
    xlen_t dividend_mag;  // high-aligned for word ops
    xlen_t divisor_mag;
    cnt_t  iter_count;    // 64 or 32
    logic  q_neg;         // negate quotient at the end
    logic  r_neg;         // negate remainder at the end
    logic  is_word;
    logic  want_rem;
    logic  is_special;    // zero divisor or overflow, no iteration
    xlen_t special_quot;
    xlen_t special_rem;
  } div_prep_t;

  // unsigned result plus what the formatter needs to finish it
  typedef struct packed {
    xlen_t quot_mag;
    xlen_t rem_mag;
    logic  q_neg;
    logic  r_neg;
    logic  is_word;
    logic  want_rem;
  } div_raw_t;

endpackage

/* common/div_op_pkg.sv */
// operation codes and request format seen at the divider request port
`include "div_defs.svh"

package div_op_pkg;

  // ==================================================
  // operation encoding
  // ==================================================

  // one-hot, matching the decode stage encoding
  typedef enum logic [7:0] {
    OP_DIV   = 8'b1000_0000, // signed, 64 bit, quotient
    OP_DIVU  = 8'b0100_0000, // unsigned, 64 bit, quotient
    OP_DIVUW = 8'b0010_0000, // unsigned, 32 bit, quotient
    OP_DIVW  = 8'b0001_0000, // signed, 32 bit, quotient
    OP_REM   = 8'b0000_1000, // signed, 64 bit, remainder
    OP_REMU  = 8'b0000_0100, // unsigned, 64 bit, remainder
    OP_REMUW = 8'b0000_0010, // unsigned, 32 bit, remainder
    OP_REMW  = 8'b0000_0001  // signed, 32 bit, remainder
  } div_op_t;

  // ==================================================
  // request
  // ==================================================

  // rs1 / rs2 values as read from the register file
  typedef struct packed {
    div_op_t               op;       // which of the eight ops
    logic [`DIV_XLEN-1:0]  dividend; // rs1
    logic [`DIV_XLEN-1:0]  divisor;  // rs2
  } div_req_t;

endpackage

/* common/div_defs.svh */
// width macros for the divider, included by every divider package and module
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// ==================================================
// datapath widths
// ==================================================

// full register width of the rv64 integer file
`define DIV_XLEN 64

// operand width of the *w operations
`define DIV_WLEN 32

// ==================================================
// iteration control
// ==================================================

// must hold the value DIV_XLEN itself
`define DIV_CNT_W 7

`endif
